// ==== Bender.yml ====
package:
  name: pacman_top

sources:
  # Design sources in compile order
  - include_dirs:
      - hw
    files:
      - hw/pacman_pkg.sv
      - hw/vga_timing.sv
      - hw/button_latch.sv
      - hw/maze_rom.sv
      - hw/player_motion.sv
      - hw/pixel_render.sv
      - hw/pacman_top.sv

  # Testbench
  - target: test
    include_dirs:
      - hw
    files:
      - test/tb_pacman_top.sv

// ==== hw/button_latch.sv ====
`timescale 1ns/1ps

module button_latch (
  input  logic             vga_pix_clk,
  input  logic             rst,
  input  pacman_pkg::btn_t btn,
  input  logic             frame_stb,
  output pacman_pkg::btn_t req
);
  import pacman_pkg::*;

  // Two sync stages, then capture
  btn_t sync_1;
  btn_t sync_2;
  btn_t cap_q;
  // Presses seen since last strobe
  btn_t sticky_q;

  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      sync_1   <= '0;
      sync_2   <= '0;
      cap_q    <= '0;
      sticky_q <= '0;
    end else begin
      sync_1 <= btn;
      sync_2 <= sync_1;
      cap_q  <= sync_2;
      // Handed over at the strobe, then start collecting again
      if (frame_stb) begin
        sticky_q <= '0;
      end else begin
        sticky_q <= sticky_q | cap_q;
      end
    end
  end

  // Includes a press captured in the strobe cycle itself
  assign req = sticky_q | cap_q;

endmodule

// ==== hw/maze_rom.sv ====
`timescale 1ns/1ps
`include "pacman_cfg.svh"

module maze_rom (
  input  logic                   vga_pix_clk,
  input  pacman_pkg::tile_addr_t probe_addr,
  output logic                   probe_wall,
  input  pacman_pkg::tile_addr_t render_addr,
  output logic                   render_wall
);

  localparam int map_depth = `PAC_MAP_STRIDE * `PAC_TILE_ROWS;

  // One bit per tile, 1 is wall
  logic wall_map [0:map_depth-1];

  //////////////////////////////
  // Maze rule
  //////////////////////////////

  initial begin
    int col;
    int row;
    for (int a = 0; a < map_depth; a++) begin
      col = a % `PAC_MAP_STRIDE;
      row = a / `PAC_MAP_STRIDE;
      wall_map[a] =
        // Padding columns past the maze
        (col >= `PAC_TILE_COLS) ||
        // Border ring
        (col == 0) || (col == `PAC_TILE_COLS - 1) ||
        (row == 0) || (row == `PAC_TILE_ROWS - 1) ||
        // Pillar grid
        ((col % 4 == 2) && (row % 4 == 2));
    end
  end

  //////////////////////////////
  // Read ports
  //////////////////////////////

  // Motion side
  always_ff @(posedge vga_pix_clk) begin
    probe_wall <= wall_map[probe_addr];
  end

  // Display side
  always_ff @(posedge vga_pix_clk) begin
    render_wall <= wall_map[render_addr];
  end

endmodule

// ==== hw/pacman_cfg.svh ====
`ifndef PACMAN_CFG_SVH
`define PACMAN_CFG_SVH

/////////////////////////////
// Display timing
/////////////////////////////

// Horizontal, line of 240 pixels
`define PAC_H_VISIBLE 224
`define PAC_H_FRONT 4
`define PAC_H_SYNC 8
`define PAC_H_BACK 4

// Vertical, frame of 296 lines
`define PAC_V_VISIBLE 288
`define PAC_V_FRONT 2
`define PAC_V_SYNC 2
`define PAC_V_BACK 4

/////////////////////////////
// Maze and player
/////////////////////////////

`define PAC_TILE_SIZE 8
`define PAC_TILE_COLS 28
`define PAC_TILE_ROWS 36
// Row pitch of the tile memory
`define PAC_MAP_STRIDE 32

`define PAC_SPRITE_SIZE 8
`define PAC_START_X 96
`define PAC_START_Y 64

// Colours as r, g, b nibbles
`define PAC_PLAYER_RGB 12'hFFF
`define PAC_WALL_RGB 12'h00F

`endif

// ==== hw/pacman_pkg.sv ====
`include "pacman_cfg.svh"

package pacman_pkg;

  // Screen coordinates
  typedef logic [8:0] pix_x_t;
  typedef logic [8:0] pix_y_t;

  // Column plus row times stride
  typedef logic [10:0] tile_addr_t;

  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  typedef struct packed {
    logic up;
    logic down;
    logic right;
    logic left;
  } btn_t;

  // Raster position plus timing flags
  typedef struct packed {
    pix_x_t sx;
    pix_y_t sy;
    logic   de;
    logic   hsync_n;
    logic   vsync_n;
    logic   frame_stb;
  } scan_t;

  typedef struct packed {
    pix_x_t x;
    pix_y_t y;
  } pos_t;

  typedef enum logic [2:0] {
    idle,
    probe_a,
    probe_b,
    apply,
    next_dir
  } motion_state_t;

  // Tile memory index of a pixel
  function automatic tile_addr_t tile_index(pix_x_t x, pix_y_t y);
    return tile_addr_t'((y / `PAC_TILE_SIZE) * `PAC_MAP_STRIDE + x / `PAC_TILE_SIZE);
  endfunction

endpackage

// ==== hw/pacman_top.sv ====
`timescale 1ns/1ps

module pacman_top (
  input  logic             vga_pix_clk,
  input  logic             rst,
  input  pacman_pkg::btn_t btn,
  output pacman_pkg::rgb_t rgb,
  output logic             hsync_n,
  output logic             vsync_n,
  output logic             de
);
  import pacman_pkg::*;

  scan_t      scan;
  btn_t       req;
  pos_t       pos;
  tile_addr_t probe_addr;
  logic       probe_wall;
  tile_addr_t render_addr;
  logic       render_wall;

  //////////////////////////////
  // Input side
  //////////////////////////////

  vga_timing vga_timing_i (
    .vga_pix_clk (vga_pix_clk),
    .rst         (rst),
    .scan        (scan)
  );

  // Presses gathered per frame
  button_latch button_latch_i (
    .vga_pix_clk (vga_pix_clk),
    .rst         (rst),
    .btn         (btn),
    .frame_stb   (scan.frame_stb),
    .req         (req)
  );

  //////////////////////////////
  // Game state
  //////////////////////////////

  player_motion player_motion_i (
    .vga_pix_clk (vga_pix_clk),
    .rst         (rst),
    .frame_stb   (scan.frame_stb),
    .req         (req),
    .probe_addr  (probe_addr),
    .probe_wall  (probe_wall),
    .pos         (pos)
  );

  // Shared by motion and display
  maze_rom maze_rom_i (
    .vga_pix_clk (vga_pix_clk),
    .probe_addr  (probe_addr),
    .probe_wall  (probe_wall),
    .render_addr (render_addr),
    .render_wall (render_wall)
  );

  //////////////////////////////
  // Output side
  //////////////////////////////

  pixel_render pixel_render_i (
    .vga_pix_clk (vga_pix_clk),
    .rst         (rst),
    .scan        (scan),
    .pos         (pos),
    .render_addr (render_addr),
    .render_wall (render_wall),
    .rgb         (rgb),
    .de          (de),
    .hsync_n     (hsync_n),
    .vsync_n     (vsync_n)
  );

endmodule

// ==== hw/pixel_render.sv ====
`timescale 1ns/1ps
`include "pacman_cfg.svh"

module pixel_render (
  input  logic                   vga_pix_clk,
  input  logic                   rst,
  input  pacman_pkg::scan_t      scan,
  input  pacman_pkg::pos_t       pos,
  output pacman_pkg::tile_addr_t render_addr,
  input  logic                   render_wall,
  output pacman_pkg::rgb_t       rgb,
  output logic                   de,
  output logic                   hsync_n,
  output logic                   vsync_n
);
  import pacman_pkg::*;

  logic in_sprite;
  logic sprite_q;

  //////////////////////////////
  // Stage 0, address and hit
  //////////////////////////////

  // Tile lookup for the current pixel
  assign render_addr = tile_index(scan.sx, scan.sy);

  // Inside the player box
  always_comb begin
    in_sprite = (scan.sx >= pos.x) && (scan.sx < pos.x + `PAC_SPRITE_SIZE) &&
                (scan.sy >= pos.y) && (scan.sy < pos.y + `PAC_SPRITE_SIZE);
  end

  // Sprite hit travels next to the ROM read
  always_ff @(posedge vga_pix_clk) begin
    sprite_q <= in_sprite;
  end

  // Timing flags delayed one stage
  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      de      <= 1'b0;
      hsync_n <= 1'b1;
      vsync_n <= 1'b1;
    end else begin
      de      <= scan.de;
      hsync_n <= scan.hsync_n;
      vsync_n <= scan.vsync_n;
    end
  end

  //////////////////////////////
  // Stage 1, colour
  //////////////////////////////

  // Player over wall over black
  always_comb begin
    if (!de) begin
      rgb = '0;
    end else if (sprite_q) begin
      rgb = rgb_t'(`PAC_PLAYER_RGB);
    end else if (render_wall) begin
      rgb = rgb_t'(`PAC_WALL_RGB);
    end else begin
      rgb = '0;
    end
  end

endmodule

// ==== hw/player_motion.sv ====
`timescale 1ns/1ps
`include "pacman_cfg.svh"

module player_motion (
  input  logic                   vga_pix_clk,
  input  logic                   rst,
  input  logic                   frame_stb,
  input  pacman_pkg::btn_t       req,
  output pacman_pkg::tile_addr_t probe_addr,
  input  logic                   probe_wall,
  output pacman_pkg::pos_t       pos
);
  import pacman_pkg::*;

  // Direction order within a frame
  localparam logic [1:0] dir_up = 2'd0;
  localparam logic [1:0] dir_down = 2'd1;
  localparam logic [1:0] dir_right = 2'd2;
  localparam logic [1:0] dir_left = 2'd3;

  // Far edge offset of the sprite box
  localparam pix_x_t edge_x = pix_x_t'(`PAC_SPRITE_SIZE - 1);
  localparam pix_y_t edge_y = pix_y_t'(`PAC_SPRITE_SIZE - 1);

  motion_state_t state;
  logic [1:0]    dir;
  btn_t          req_q;
  logic          dir_req;
  logic          blocked_a;
  logic          second;
  pix_x_t        probe_x;
  pix_y_t        probe_y;

  //////////////////////////////
  // Probe point
  //////////////////////////////

  always_comb begin
    case (dir)
      dir_up:    dir_req = req_q.up;
      dir_down:  dir_req = req_q.down;
      dir_right: dir_req = req_q.right;
      default:   dir_req = req_q.left;
    endcase
  end

  // Two tiles under the leading edge of the moved box
  assign second = (state == probe_b);

  always_comb begin
    case (dir)
      dir_up: begin
        probe_x = second ? pos.x + edge_x : pos.x;
        probe_y = pos.y - 1'b1;
      end
      dir_down: begin
        probe_x = second ? pos.x + edge_x : pos.x;
        probe_y = pos.y + edge_y + 1'b1;
      end
      dir_right: begin
        probe_x = pos.x + edge_x + 1'b1;
        probe_y = second ? pos.y + edge_y : pos.y;
      end
      default: begin
        probe_x = pos.x - 1'b1;
        probe_y = second ? pos.y + edge_y : pos.y;
      end
    endcase
  end

  assign probe_addr = tile_index(probe_x, probe_y);

  //////////////////////////////
  // Step FSM
  //////////////////////////////

  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      state     <= idle;
      dir       <= dir_up;
      req_q     <= '0;
      blocked_a <= 1'b0;
      pos.x     <= pix_x_t'(`PAC_START_X);
      pos.y     <= pix_y_t'(`PAC_START_Y);
    end else begin
      case (state)
        idle: begin
          // Sample requests once per frame
          if (frame_stb) begin
            req_q <= req;
            dir   <= dir_up;
            state <= next_dir;
          end
        end
        next_dir: begin
          // Skip directions not requested
          if (dir_req) begin
            state <= probe_a;
          end else if (dir == dir_left) begin
            state <= idle;
          end else begin
            dir <= dir + 1'b1;
          end
        end
        probe_a: state <= probe_b;
        probe_b: begin
          // ROM returns the first tile here
          blocked_a <= probe_wall;
          state     <= apply;
        end
        apply: begin
          // Second tile on probe_wall now
          if (!blocked_a && !probe_wall) begin
            case (dir)
              dir_up:    pos.y <= pos.y - 1'b1;
              dir_down:  pos.y <= pos.y + 1'b1;
              dir_right: pos.x <= pos.x + 1'b1;
              default:   pos.x <= pos.x - 1'b1;
            endcase
          end
          if (dir == dir_left) begin
            state <= idle;
          end else begin
            dir   <= dir + 1'b1;
            state <= next_dir;
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

// ==== hw/vga_timing.sv ====
`timescale 1ns/1ps
`include "pacman_cfg.svh"

module vga_timing (
  input  logic              vga_pix_clk,
  input  logic              rst,
  output pacman_pkg::scan_t scan
);
  import pacman_pkg::*;

  // Line and frame lengths
  localparam int h_total = `PAC_H_VISIBLE + `PAC_H_FRONT + `PAC_H_SYNC + `PAC_H_BACK;
  localparam int v_total = `PAC_V_VISIBLE + `PAC_V_FRONT + `PAC_V_SYNC + `PAC_V_BACK;
  // Sync windows
  localparam int hs_start = `PAC_H_VISIBLE + `PAC_H_FRONT;
  localparam int hs_end = hs_start + `PAC_H_SYNC;
  localparam int vs_start = `PAC_V_VISIBLE + `PAC_V_FRONT;
  localparam int vs_end = vs_start + `PAC_V_SYNC;

  pix_x_t sx_nxt;
  pix_y_t sy_nxt;
  logic   line_end;
  logic   frame_end;

  //////////////////////////////
  // Next position
  //////////////////////////////

  assign line_end = (scan.sx == pix_x_t'(h_total - 1));
  assign frame_end = (scan.sy == pix_y_t'(v_total - 1));

  always_comb begin
    sx_nxt = line_end ? '0 : scan.sx + 1'b1;
    sy_nxt = scan.sy;
    // Row advances on line wrap
    if (line_end) begin
      sy_nxt = frame_end ? '0 : scan.sy + 1'b1;
    end
  end

  //////////////////////////////
  // Registered scan state
  //////////////////////////////

  // Flags decoded from the next position so they line up with sx, sy
  always_ff @(posedge vga_pix_clk) begin
    if (rst) begin
      scan.sx        <= '0;
      scan.sy        <= '0;
      scan.de        <= 1'b0;
      scan.hsync_n   <= 1'b1;
      scan.vsync_n   <= 1'b1;
      scan.frame_stb <= 1'b0;
    end else begin
      scan.sx        <= sx_nxt;
      scan.sy        <= sy_nxt;
      scan.de        <= (sx_nxt < `PAC_H_VISIBLE) && (sy_nxt < `PAC_V_VISIBLE);
      scan.hsync_n   <= !((sx_nxt >= hs_start) && (sx_nxt < hs_end));
      scan.vsync_n   <= !((sy_nxt >= vs_start) && (sy_nxt < vs_end));
      // First pixel of the first blanking line
      scan.frame_stb <= (sx_nxt == '0) && (sy_nxt == pix_y_t'(`PAC_V_VISIBLE));
    end
  end

endmodule

// ==== pacman_top.f ====
+incdir+hw
hw/pacman_pkg.sv
hw/vga_timing.sv
hw/button_latch.sv
hw/maze_rom.sv
hw/player_motion.sv
hw/pixel_render.sv
hw/pacman_top.sv
test/tb_pacman_top.sv

// ==== test/tb_pacman_top.sv ====
`timescale 1ns/1ps
`include "pacman_cfg.svh"

module tb_pacman_top;
  import pacman_pkg::*;

  localparam int line_cycles = `PAC_H_VISIBLE + `PAC_H_FRONT + `PAC_H_SYNC + `PAC_H_BACK;
  localparam int frame_lines = `PAC_V_VISIBLE + `PAC_V_FRONT + `PAC_V_SYNC + `PAC_V_BACK;
  localparam int frame_cycles = line_cycles * frame_lines;
  // Press begins roughly a third into the visible area
  localparam int press_delay = 20000;
  localparam int n_steps = 12;

  // One table entry, press repeated for a number of frames
  typedef struct packed {
    btn_t b;
    int   len;
    int   frames;
    pos_t exp;
  } step_t;

  logic vga_pix_clk = 1'b0;
  logic rst;
  btn_t btn;
  rgb_t rgb;
  logic hsync_n;
  logic vsync_n;
  logic de;

  step_t step_tab [0:n_steps-1];
  int    cycle_cnt = 0;
  int    cycle_limit = 32'h7fff_ffff;

  pacman_top dut_i (
    .vga_pix_clk (vga_pix_clk),
    .rst         (rst),
    .btn         (btn),
    .rgb         (rgb),
    .hsync_n     (hsync_n),
    .vsync_n     (vsync_n),
    .de          (de)
  );

  always #5 vga_pix_clk = ~vga_pix_clk;

  // Run limit
  always @(posedge vga_pix_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  end

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_pos(string name, pos_t got, pos_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_rgb(string name, rgb_t got, rgb_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  // Pixel and line counts
  task automatic check_count(string name, pix_x_t got, pix_x_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  //////////////////////////////
  // Reference maze
  //////////////////////////////

  // Border ring plus pillar every fourth tile at offset 2
  function automatic rgb_t maze_colour(int x, int y);
    int col;
    int row;
    logic wall;
    col = x / 8;
    row = y / 8;
    wall = (col == 0) || (col == 27) || (row == 0) || (row == 35) ||
           ((col % 4 == 2) && (row % 4 == 2));
    return wall ? rgb_t'(12'h00F) : rgb_t'(12'h000);
  endfunction

  task automatic set_step(int idx, btn_t b, int len, int frames, int x, int y);
    step_tab[idx].b = b;
    step_tab[idx].len = len;
    step_tab[idx].frames = frames;
    step_tab[idx].exp.x = pix_x_t'(x);
    step_tab[idx].exp.y = pix_y_t'(y);
  endtask

  // Buttons as up, down, right, left; expected position after the last frame
  task automatic load_table();
    set_step(0, 4'b0010, 40000, 1, 97, 64);
    set_step(1, 4'b0010, 40000, 1, 98, 64);
    set_step(2, 4'b0100, 40000, 1, 98, 65);
    set_step(3, 4'b0100, 3, 1, 98, 66);
    // Diagonal, up then left
    set_step(4, 4'b1001, 3, 1, 97, 65);
    set_step(5, 4'b0010, 3, 1, 98, 65);
    set_step(6, 4'b0000, 0, 1, 98, 65);
    // Runs into the top border and stays under it
    set_step(7, 4'b1000, 40000, 70, 98, 8);
    set_step(8, 4'b0010, 40000, 8, 106, 8);
    // Pillar at column 14, row 2 blocks the way down
    set_step(9, 4'b0100, 40000, 1, 106, 8);
    set_step(10, 4'b0001, 3, 2, 104, 8);
    set_step(11, 4'b0100, 3, 1, 104, 9);
  endtask

  //////////////////////////////
  // Stimulus and frame scanner
  //////////////////////////////

  task automatic press(btn_t b, int len);
    if (len > 0) begin
      repeat (press_delay) @(posedge vga_pix_clk);
      btn <= b;
      repeat (len) @(posedge vga_pix_clk);
      btn <= '0;
    end
  endtask

  task automatic wait_vsync_fall();
    logic prev_vs;
    prev_vs = vsync_n;
    @(negedge vga_pix_clk);
    while (!(prev_vs && !vsync_n)) begin
      prev_vs = vsync_n;
      @(negedge vga_pix_clk);
    end
  endtask

  // One frame from vsync fall to the next, checking every output pixel
  task automatic scan_frame(output pos_t first_white, output logic found);
    logic prev_de;
    logic prev_hs;
    logic prev_vs;
    logic done;
    int   x;
    int   lines;
    int   hs_len;
    rgb_t exp_rgb;
    prev_de = de;
    prev_hs = hsync_n;
    prev_vs = vsync_n;
    done = 1'b0;
    x = 0;
    lines = 0;
    hs_len = 0;
    found = 1'b0;
    first_white = '0;
    while (!done) begin
      @(negedge vga_pix_clk);
      if (de) begin
        if (!prev_de) begin
          x = 0;
        end
        // First sprite pixel in raster order is its top left corner
        if (!found && (rgb == rgb_t'(12'hFFF))) begin
          found = 1'b1;
          first_white.x = pix_x_t'(x);
          first_white.y = pix_y_t'(lines);
        end
        // 8x8 white box from that corner, maze everywhere else
        if (found && (x >= first_white.x) && (x < first_white.x + 8) &&
            (lines >= first_white.y) && (lines < first_white.y + 8)) begin
          exp_rgb = rgb_t'(12'hFFF);
        end else begin
          exp_rgb = maze_colour(x, lines);
        end
        check_rgb("rgb", rgb, exp_rgb);
        x++;
      end else begin
        check_rgb("rgb_blank", rgb, '0);
        if (prev_de) begin
          check_count("de_pixels_per_line", pix_x_t'(x), pix_x_t'(`PAC_H_VISIBLE));
          lines++;
        end
      end
      // Sync pulse width measured at its rising edge
      if (!hsync_n) begin
        hs_len++;
      end else if (!prev_hs) begin
        check_count("hsync_n_width", pix_x_t'(hs_len), pix_x_t'(`PAC_H_SYNC));
        hs_len = 0;
      end
      if (prev_vs && !vsync_n) begin
        done = 1'b1;
      end
      prev_de = de;
      prev_hs = hsync_n;
      prev_vs = vsync_n;
    end
    check_count("de_lines_per_frame", pix_x_t'(lines), pix_x_t'(`PAC_V_VISIBLE));
  endtask

  task automatic check_frame(pos_t found_pos, logic found, pos_t exp_pos, logic exp_valid);
    check_bit("player_found", found, 1'b1);
    if (exp_valid) begin
      check_pos("pos", found_pos, exp_pos);
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    pos_t found_pos;
    pos_t exp_pos;
    logic found;
    logic exp_valid;
    int   total_frames;
    rst = 1'b1;
    btn = '0;
    load_table();
    total_frames = 1;
    for (int r = 0; r < n_steps; r++) begin
      total_frames += step_tab[r].frames;
    end
    cycle_limit = (total_frames + 4) * frame_cycles;

    repeat (5) @(posedge vga_pix_clk);
    rst <= 1'b0;

    // Idle outputs straight after reset
    @(negedge vga_pix_clk);
    check_bit("de", de, 1'b0);
    check_bit("hsync_n", hsync_n, 1'b1);
    check_bit("vsync_n", vsync_n, 1'b1);
    check_rgb("rgb", rgb, '0);

    wait_vsync_fall();
    exp_pos.x = pix_x_t'(`PAC_START_X);
    exp_pos.y = pix_y_t'(`PAC_START_Y);
    exp_valid = 1'b1;

    // Frame shows the result of the presses made in the frame before
    for (int r = 0; r < n_steps; r++) begin
      for (int f = 0; f < step_tab[r].frames; f++) begin
        fork
          scan_frame(found_pos, found);
          press(step_tab[r].b, step_tab[r].len);
        join
        check_frame(found_pos, found, exp_pos, exp_valid);
        exp_valid = (f == step_tab[r].frames - 1);
        exp_pos = step_tab[r].exp;
      end
    end
    scan_frame(found_pos, found);
    check_frame(found_pos, found, exp_pos, exp_valid);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule
